// File: mac_cfg_pkg.sv
package mac_cfg_pkg;

  //======================================================================
  // datapath geometry
  //======================================================================

  localparam int num_lanes = 64;    // multiply lanes per cell
  localparam int operand_w = 16;    // int16 weight and activation
  localparam int acc_w     = 44;    // sign-extended product width
  localparam int out_w     = 38;    // result bits kept at the output

  //======================================================================
  // adder tree and pipeline
  //======================================================================

  localparam int tree_levels = 6;   // log2 of num_lanes
  localparam int mid_level   = 3;   // registered after this level, 8 partials

  // edges from input sample to mac_out_data
  localparam int pipe_latency = 3;

endpackage

// File: mac_type_pkg.sv
package mac_type_pkg;

  //======================================================================
  // scalar types
  //======================================================================

  typedef logic signed [mac_cfg_pkg::operand_w-1:0] operand_t;  // weight or activation
  typedef logic signed [mac_cfg_pkg::acc_w-1:0]     acc_t;      // product or partial sum
  typedef logic        [mac_cfg_pkg::out_w-1:0]     out_t;      // truncated result

  //======================================================================
  // lane vectors
  //======================================================================

  // lane 0 sits in the low 16 bits of the bus
  typedef operand_t [mac_cfg_pkg::num_lanes-1:0] lane_vec_t;

  // one sign-extended product per lane
  typedef acc_t [mac_cfg_pkg::num_lanes-1:0] prod_vec_t;

endpackage

// File: mac_prod_if.sv
`timescale 1ns/100ps

interface mac_prod_if;

  mac_type_pkg::prod_vec_t prod;       // registered sign-extended products
  logic                    prod_pvld;  // travels with prod

  // multiplier array side
  modport src (
    output prod,
    output prod_pvld
  );

  // adder tree side
  modport dst (
    input prod,
    input prod_pvld
  );

endinterface

// File: mac_mult_array.sv
`timescale 1ns/100ps

module mac_mult_array (
  input  logic                    nvdla_core_clk,
  input  logic                    rst,
  input  mac_type_pkg::lane_vec_t wt,
  input  mac_type_pkg::lane_vec_t dat,
  input  logic                    in_pvld,
  mac_prod_if.src                 prod_out
);

  localparam int mult_w = 2 * mac_cfg_pkg::operand_w;        // full product width
  localparam int ext_w  = mac_cfg_pkg::acc_w - mult_w;       // sign bits added

  mac_type_pkg::prod_vec_t prod_d;

  //======================================================================
  // signed multipliers with sign extension
  //======================================================================

  for (genvar i = 0; i < mac_cfg_pkg::num_lanes; i++) begin : g_lane
    logic signed [mult_w-1:0] mult_res;

    assign mult_res  = $signed(wt[i]) * $signed(dat[i]);   // int16 x int16
    assign prod_d[i] = {{ext_w{mult_res[mult_w-1]}}, mult_res};
  end

  //======================================================================
  // first pipeline register
  //======================================================================

  always_ff @(posedge nvdla_core_clk) begin
    prod_out.prod <= prod_d;  // loads every edge
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      prod_out.prod_pvld <= 1'b0;
    end else begin
      prod_out.prod_pvld <= in_pvld;
    end
  end

endmodule

// File: mac_adder_tree.sv
`timescale 1ns/100ps

module mac_adder_tree (
  input  logic               nvdla_core_clk,
  input  logic               rst,
  mac_prod_if.dst            prod_in,
  output mac_type_pkg::acc_t sum,
  output logic               sum_pvld
);

  localparam int num_mid = mac_cfg_pkg::num_lanes >> mac_cfg_pkg::mid_level;  // 8 partials

  mac_type_pkg::acc_t [num_mid-1:0] mid_d;
  mac_type_pkg::acc_t [num_mid-1:0] mid_q;
  logic                             mid_pvld;
  mac_type_pkg::acc_t               sum_d;

  // pairwise reduction in place, levels first_lvl..last_lvl
  // after level l the first num_lanes>>l entries hold the partial sums
  function automatic mac_type_pkg::prod_vec_t reduce_levels(
    input mac_type_pkg::prod_vec_t node,
    input int                      first_lvl,
    input int                      last_lvl
  );
    for (int l = first_lvl; l <= last_lvl; l++) begin
      for (int i = 0; i < (mac_cfg_pkg::num_lanes >> l); i++) begin
        node[i] = node[2*i] + node[2*i+1];  // wraps at acc_w
      end
    end
    return node;
  endfunction

  //======================================================================
  // levels 1 to 3, 64 products down to 8 partials
  //======================================================================

  always_comb begin : lo_reduce
    mac_type_pkg::prod_vec_t node;

    node = reduce_levels(prod_in.prod, 1, mac_cfg_pkg::mid_level);
    for (int j = 0; j < num_mid; j++) begin
      mid_d[j] = node[j];
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    mid_q <= mid_d;
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      mid_pvld <= 1'b0;
    end else begin
      mid_pvld <= prod_in.prod_pvld;
    end
  end

  //======================================================================
  // levels 4 to 6, 8 partials down to the total
  //======================================================================

  always_comb begin : hi_reduce
    mac_type_pkg::prod_vec_t node;

    node  = mac_type_pkg::prod_vec_t'(mid_q);  // upper lanes zero, never read
    node  = reduce_levels(node, mac_cfg_pkg::mid_level + 1, mac_cfg_pkg::tree_levels);
    sum_d = node[0];
  end

  always_ff @(posedge nvdla_core_clk) begin
    sum <= sum_d;
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      sum_pvld <= 1'b0;
    end else begin
      sum_pvld <= mid_pvld;
    end
  end

endmodule

// File: mac_out_stage.sv
`timescale 1ns/100ps

module mac_out_stage (
  input  logic               nvdla_core_clk,
  input  logic               rst,
  input  logic               cfg_reg_en,
  input  mac_type_pkg::acc_t sum,
  input  logic               sum_pvld,
  output mac_type_pkg::out_t mac_out_data,
  output logic               mac_out_pvld
);

  mac_type_pkg::out_t sum_trunc;

  assign sum_trunc = sum[mac_cfg_pkg::out_w-1:0];  // low 38 bits only

  //======================================================================
  // output register and valid pulse
  //======================================================================

  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      mac_out_data <= '0;
    end else if (sum_pvld) begin
      mac_out_data <= sum_trunc;  // loads even when the pulse is dropped
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      mac_out_pvld <= 1'b0;
    end else begin
      mac_out_pvld <= sum_pvld & ~cfg_reg_en;  // cfg_reg_en drops this pulse
    end
  end

endmodule

// File: cmac_dot_core.sv
`timescale 1ns/100ps

module cmac_dot_core (
  input  logic                    nvdla_core_clk,
  input  logic                    rst,
  input  logic                    cfg_reg_en,
  input  logic                    mac_in_pvld,
  input  mac_type_pkg::lane_vec_t wt_actv_data,
  input  mac_type_pkg::lane_vec_t dat_actv_data,
  output mac_type_pkg::out_t      mac_out_data,
  output logic                    mac_out_pvld
);

  mac_type_pkg::acc_t sum;
  logic               sum_pvld;

  mac_prod_if u_prod_if ();

  //======================================================================
  // stage 1, multipliers
  //======================================================================

  mac_mult_array u_mult_array (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .wt             (wt_actv_data),   // 64 lanes of int16
    .dat            (dat_actv_data),
    .in_pvld        (mac_in_pvld),
    .prod_out       (u_prod_if.src)
  );

  //======================================================================
  // stages 2 and 3, adder tree
  //======================================================================

  mac_adder_tree u_adder_tree (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .prod_in        (u_prod_if.dst),
    .sum            (sum),
    .sum_pvld       (sum_pvld)
  );

  //======================================================================
  // stage 4, output register
  //======================================================================

  mac_out_stage u_out_stage (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .cfg_reg_en     (cfg_reg_en),
    .sum            (sum),
    .sum_pvld       (sum_pvld),
    .mac_out_data   (mac_out_data),
    .mac_out_pvld   (mac_out_pvld)    // one cycle per strobed input
  );

endmodule

// File: tb_cmac_dot_core.sv
`timescale 1ns/100ps

module tb_cmac_dot_core;

  localparam int clk_period = 20;
  localparam int n_idle     = 5;
  localparam int n_rand     = 200;
  localparam int n_corner   = 3;
  localparam int n_gap      = 150;
  localparam int n_en       = 150;
  localparam int n_tests    = 5;
  localparam int n_drain    = mac_cfg_pkg::pipe_latency + 3;
  localparam int total_cycles = 2 + n_idle + n_rand + n_corner + n_gap + n_en
                              + n_tests * (n_drain + 1);

  logic                    nvdla_core_clk;
  logic                    rst;
  logic                    cfg_reg_en;
  logic                    mac_in_pvld;
  mac_type_pkg::lane_vec_t wt_actv_data;
  mac_type_pkg::lane_vec_t dat_actv_data;
  mac_type_pkg::out_t      mac_out_data;
  logic                    mac_out_pvld;

  integer seed;
  int     err_cnt;
  int     chk_cnt;
  int     pulse_cnt;
  int     supp_cnt;

  mac_type_pkg::out_t                   exp_q[$];     // sums of strobed items, in order
  mac_type_pkg::out_t                   exp_data;     // value mac_out_data should hold
  logic [mac_cfg_pkg::pipe_latency-1:0] strobe_hist;  // bit 0 is the previous edge

  cmac_dot_core UUT (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .cfg_reg_en     (cfg_reg_en),
    .mac_in_pvld    (mac_in_pvld),
    .wt_actv_data   (wt_actv_data),
    .dat_actv_data  (dat_actv_data),
    .mac_out_data   (mac_out_data),
    .mac_out_pvld   (mac_out_pvld)
  );

  always #(clk_period / 2) nvdla_core_clk = ~nvdla_core_clk;

  //======================================================================
  // reference model and stimulus helpers
  //======================================================================

  // 64-bit integer dot product, then keep the low out_w bits
  function automatic mac_type_pkg::out_t model_dot(
    input mac_type_pkg::lane_vec_t w,
    input mac_type_pkg::lane_vec_t d
  );
    longint total;

    total = 0;
    for (int i = 0; i < mac_cfg_pkg::num_lanes; i++) begin
      total = total + longint'(w[i]) * longint'(d[i]);
    end
    return total[mac_cfg_pkg::out_w-1:0];
  endfunction

  function automatic mac_type_pkg::lane_vec_t fill_lanes(input mac_type_pkg::operand_t v);
    mac_type_pkg::lane_vec_t vec;

    for (int i = 0; i < mac_cfg_pkg::num_lanes; i++) begin
      vec[i] = v;
    end
    return vec;
  endfunction

  task automatic rand_lanes(output mac_type_pkg::lane_vec_t vec);
    for (int i = 0; i < mac_cfg_pkg::num_lanes; i++) begin
      vec[i] = mac_type_pkg::operand_t'($random(seed));
    end
  endtask

  // inputs change 2 ns after the edge and are sampled at the next one
  task automatic drive_cycle(
    input logic                    pvld,
    input mac_type_pkg::lane_vec_t w,
    input mac_type_pkg::lane_vec_t d,
    input logic                    en
  );
    @(posedge nvdla_core_clk);
    #2;
    mac_in_pvld   = pvld;
    wt_actv_data  = w;
    dat_actv_data = d;
    cfg_reg_en    = en;
    if (pvld) begin
      exp_q.push_back(model_dot(w, d));
    end
  endtask

  task automatic drive_idle();
    mac_type_pkg::lane_vec_t w;
    mac_type_pkg::lane_vec_t d;

    rand_lanes(w);  // junk on the buses while idle
    rand_lanes(d);
    drive_cycle(1'b0, w, d, 1'b0);
  endtask

  task automatic drain_pipe();
    while (exp_q.size() != 0) begin
      drive_idle();
    end
    drive_idle();
  endtask

  //======================================================================
  // compare tasks
  //======================================================================

  task automatic check_data(
    input mac_type_pkg::out_t got,
    input mac_type_pkg::out_t exp,
    input string              what
  );
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL time %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pvld(input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      if (exp) begin
        $display("time %0t: expected output pulse is missing", $time);
      end else begin
        $display("time %0t: output pulse where none was expected", $time);
      end
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    $display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
  endtask

  //======================================================================
  // output monitor, 1 ns after each edge
  //======================================================================

  always @(posedge nvdla_core_clk) begin
    #1;
    if (rst) begin
      strobe_hist = '0;
      exp_data    = '0;
    end else begin
      if (strobe_hist[mac_cfg_pkg::pipe_latency-1]) begin  // item strobed 3 edges ago
        exp_data = exp_q.pop_front();
        check_pvld(mac_out_pvld, ~cfg_reg_en);
        if (cfg_reg_en) begin
          supp_cnt++;
        end
      end else begin
        check_pvld(mac_out_pvld, 1'b0);
      end
      if (mac_out_pvld) begin
        pulse_cnt++;
      end
      check_data(mac_out_data, exp_data, "mac_out_data");  // also checks the hold
      strobe_hist = {strobe_hist[mac_cfg_pkg::pipe_latency-2:0], mac_in_pvld};
    end
  end

  //======================================================================
  // test sequence
  //======================================================================

  initial begin
    mac_type_pkg::lane_vec_t w;
    mac_type_pkg::lane_vec_t d;
    int                      e0;

    seed           = 32'h2139;
    err_cnt        = 0;
    chk_cnt        = 0;
    pulse_cnt      = 0;
    supp_cnt       = 0;
    nvdla_core_clk = 1'b0;
    rst            = 1'b1;
    cfg_reg_en     = 1'b0;
    mac_in_pvld    = 1'b0;
    wt_actv_data   = '0;
    dat_actv_data  = '0;

    repeat (2) @(posedge nvdla_core_clk);
    #2;
    rst = 1'b0;

    // 1: reset state
    e0 = err_cnt;
    repeat (n_idle) drive_idle();
    check_data(mac_out_data, '0, "data after reset");
    report_test(1, "reset state", e0);

    // 2: back-to-back random items
    e0 = err_cnt;
    for (int n = 0; n < n_rand; n++) begin
      rand_lanes(w);
      rand_lanes(d);
      drive_cycle(1'b1, w, d, 1'b0);
    end
    drain_pipe();
    report_test(2, "back-to-back random", e0);

    // 3: corner operands, model checked against hand values first
    e0 = err_cnt;
    check_data(model_dot(fill_lanes(16'sh8000), fill_lanes(16'sh8000)),
               38'd68719476736, "model min x min");
    check_data(model_dot(fill_lanes(16'sh8000), fill_lanes(16'sh7fff)),
               38'd206160527360, "model min x max");
    drive_cycle(1'b1, fill_lanes(16'sh8000), fill_lanes(16'sh8000), 1'b0);
    drive_cycle(1'b1, fill_lanes(16'sh8000), fill_lanes(16'sh7fff), 1'b0);
    drive_cycle(1'b1, '0, '0, 1'b0);
    drain_pipe();
    report_test(3, "corner operands", e0);

    // 4: random gaps between strobes
    e0 = err_cnt;
    for (int n = 0; n < n_gap; n++) begin
      rand_lanes(w);
      rand_lanes(d);
      drive_cycle((($random(seed) & 1) != 0), w, d, 1'b0);
    end
    drain_pipe();
    report_test(4, "random gaps", e0);

    // 5: cfg_reg_en raised at random output edges
    e0 = err_cnt;
    for (int n = 0; n < n_en; n++) begin
      rand_lanes(w);
      rand_lanes(d);
      drive_cycle((($random(seed) & 3) != 0), w, d, (($random(seed) & 3) == 0));
    end
    drain_pipe();
    if (supp_cnt == 0) begin
      $display("no pulse was ever suppressed by cfg_reg_en");
      err_cnt++;
    end
    report_test(5, "cfg_reg_en suppression", e0);

    $display("checks %0d, errors %0d, pulses %0d, suppressed %0d",
             chk_cnt, err_cnt, pulse_cnt, supp_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // run length with a factor of two margin
  initial begin
    #(total_cycles * clk_period * 2);
    $display("watchdog expired after %0d cycles, the tests did not finish", total_cycles * 2);
    $display("Errors found");
    $finish;
  end

endmodule

// File: sources.f
mac_cfg_pkg.sv
mac_type_pkg.sv
mac_prod_if.sv
mac_mult_array.sv
mac_adder_tree.sv
mac_out_stage.sv
cmac_dot_core.sv
tb_cmac_dot_core.sv

// File: Makefile
# Verilator flow for the int16 dot-product engine
# any variable below can be overridden, e.g. make sim LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_cmac_dot_core
RTL_TOP   ?= cmac_dot_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
JOBS      ?= 4
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

# lint the design alone, then together with the testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

# pass or fail comes from the log, not from the exit code of the run
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q -x "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
